// ==== rtl/cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

    // ----------------------------------------
    // widths
    // ----------------------------------------
    localparam int addr_width = 32;
    localparam int data_width = 32;

    // ----------------------------------------
    // address map
    // ----------------------------------------

    // boot vector, lands in kseg1 so the first fetch is uncached
    localparam logic [31:0] reset_pc   = 32'hbfc0_0000;

    localparam logic [31:0] kseg0_base = 32'h8000_0000;
    localparam logic [31:0] kseg1_base = 32'ha000_0000;

    // drops the segment select bits
    localparam logic [31:0] seg_mask   = 32'h1fff_ffff;

    // ----------------------------------------
    // bus types
    // ----------------------------------------

    // request fsm of one sram-like port
    typedef enum logic [1:0] {
        hs_idle = 2'b00,
        hs_req  = 2'b01,
        hs_wait = 2'b10
    } hs_state_t;

    // encodes the size field of the sram-like bus
    typedef enum logic [1:0] {
        size_byte = 2'b00,
        size_half = 2'b01,
        size_word = 2'b10
    } mem_size_t;

endpackage

`default_nettype wire

// ==== rtl/mmu.sv ====
`timescale 1ns/1ps
`default_nettype none

module mmu (
    input  logic [cpu_pkg::addr_width-1:0] vaddr,
    output logic [cpu_pkg::addr_width-1:0] paddr,
    output logic                           cached
);
    import cpu_pkg::*;

    logic in_kseg0;
    logic in_kseg1;

    // segment is picked by the top three bits
    assign in_kseg0 = (vaddr[31:29] == kseg0_base[31:29]);
    assign in_kseg1 = (vaddr[31:29] == kseg1_base[31:29]);

    always_comb begin
        if (in_kseg0 || in_kseg1) begin
            paddr = vaddr & seg_mask;
        end else begin
            // kuseg and kseg2/3 are mapped flat
            paddr = vaddr;
        end
    end

    // only kseg0 goes through the cache
    assign cached = in_kseg0;

endmodule

`default_nettype wire

// ==== rtl/sram_like_handshake.sv ====
`timescale 1ns/1ps
`default_nettype none

module sram_like_handshake (
    input  logic               clk,
    input  logic               resetn,
    input  logic [31:0]        unique_id,
    input  logic               need_req,
    input  logic               addr_ok,
    input  logic               data_ok,
    output logic               req,
    output logic               busy,
    output cpu_pkg::hs_state_t state
);
    import cpu_pkg::*;

    logic [31:0] served_id;
    logic        served_valid;
    logic        new_id;
    logic        start;

    // an id that was served once is never requested again
    assign new_id = !served_valid || (unique_id != served_id);
    assign start  = (state == hs_idle) && need_req && new_id;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state        <= hs_idle;
            served_valid <= 1'b0;
        end else begin
            case (state)
                hs_idle: begin
                    if (start) begin
                        state        <= hs_req;
                        served_valid <= 1'b1;
                    end
                end
                hs_req: begin
                    // zero-latency slaves may return data with the address ack
                    if (addr_ok) begin
                        state <= data_ok ? hs_idle : hs_wait;
                    end
                end
                hs_wait: begin
                    if (data_ok) begin
                        state <= hs_idle;
                    end
                end
                default: state <= hs_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            served_id <= unique_id;
        end
    end

    assign req  = (state == hs_req);
    assign busy = need_req && ((state != hs_idle) || new_id) && !data_ok;

    // ----------------------------------------
    // bus protocol checks
    // ----------------------------------------

    // a waiting request keeps both req and the access it stands for
    a_req_held: assert property (@(posedge clk) disable iff (!resetn)
        (req && !addr_ok) |=> (req && $stable(unique_id)))
        else $error("req dropped or request changed before addr_ok");

    a_no_stray_data_ok: assert property (@(posedge clk) disable iff (!resetn)
        (state == hs_idle) |-> !data_ok)
        else $error("data_ok with no access outstanding");

endmodule

`default_nettype wire

// ==== rtl/rdata_latch.sv ====
`timescale 1ns/1ps
`default_nettype none

module rdata_latch (
    input  logic                           clk,
    input  logic                           resetn,
    input  logic                           stall,
    input  logic                           flush,
    input  logic                           data_ok,
    input  logic [cpu_pkg::data_width-1:0] rdata,
    output logic [cpu_pkg::data_width-1:0] out,
    output logic                           valid
);
    import cpu_pkg::*;

    logic [data_width-1:0] word_q;
    logic                  held;

    always_ff @(posedge clk) begin
        if (data_ok) begin
            word_q <= rdata;
        end
    end

    // word stays held only while the stage cannot take it
    always_ff @(posedge clk) begin
        if (!resetn || flush) begin
            held <= 1'b0;
        end else if (data_ok) begin
            held <= stall;
        end else if (!stall) begin
            held <= 1'b0;
        end
    end

    // bypass in the arrival cycle
    assign out   = data_ok ? rdata : word_q;
    assign valid = data_ok || held;

endmodule

`default_nettype wire

// ==== rtl/fetch_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_unit (
    input  logic                           clk,
    input  logic                           resetn,
    input  logic                           f_stall,
    input  logic                           imem_busy,
    input  logic                           f_instr_valid,
    output logic [cpu_pkg::addr_width-1:0] pc
);
    import cpu_pkg::*;

    logic hold;
    logic advance;

    // ----------------------------------------
    // fetch stage control
    // ----------------------------------------

    // outside stall or a fetch still on the bus
    assign hold    = f_stall || imem_busy;

    // instruction consumed this cycle
    assign advance = f_instr_valid && !hold;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            pc <= reset_pc;
        end else if (advance) begin
            pc <= pc + 32'd4;
        end
    end

    // ----------------------------------------
    // checks
    // ----------------------------------------
    a_pc_aligned: assert property (@(posedge clk) disable iff (!resetn)
        pc[1:0] == 2'b00)
        else $error("pc not word aligned");

    // a delivered word and a pending fetch for the same pc cannot coexist
    a_valid_not_busy: assert property (@(posedge clk) disable iff (!resetn)
        f_instr_valid |-> !imem_busy)
        else $error("instruction valid while fetch still busy");

endmodule

`default_nettype wire

// ==== rtl/mem_frontend.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_frontend (
    input  logic                           clk,
    input  logic                           resetn,

    input  logic                           f_stall,
    input  logic                           m_stall,
    input  logic                           m_flush,

    // memory stage command
    input  logic                           m_req,
    input  logic                           m_wr,
    input  cpu_pkg::mem_size_t             m_size,
    input  logic [cpu_pkg::addr_width-1:0] m_vaddr,
    input  logic [cpu_pkg::data_width-1:0] m_wdata,

    // instruction sram-like bus
    output logic                           inst_req,
    output logic                           inst_wr,
    output cpu_pkg::mem_size_t             inst_size,
    output logic [cpu_pkg::addr_width-1:0] inst_addr,
    output logic [cpu_pkg::data_width-1:0] inst_wdata,
    input  logic [cpu_pkg::data_width-1:0] inst_rdata,
    input  logic                           inst_addr_ok,
    input  logic                           inst_data_ok,
    output logic                           icached,

    // data sram-like bus
    output logic                           data_req,
    output logic                           data_wr,
    output cpu_pkg::mem_size_t             data_size,
    output logic [cpu_pkg::addr_width-1:0] data_addr,
    output logic [cpu_pkg::data_width-1:0] data_wdata,
    input  logic [cpu_pkg::data_width-1:0] data_rdata,
    input  logic                           data_addr_ok,
    input  logic                           data_data_ok,
    output logic                           dcached,

    // fetch stage
    output logic [cpu_pkg::addr_width-1:0] f_pc,
    output logic [cpu_pkg::data_width-1:0] f_instr,
    output logic                           f_instr_valid,

    // memory stage
    output logic [cpu_pkg::data_width-1:0] m_rdata,
    output logic                           m_rdata_valid,
    output logic                           m_busy,
    output logic                           m_done
);
    import cpu_pkg::*;

    logic        imem_busy;
    logic        dmem_busy;
    hs_state_t   imem_state;
    logic [31:0] data_count;
    logic        load_ok;

    // ----------------------------------------
    // instruction path
    // ----------------------------------------
    fetch_unit u_fetch_unit (
        .clk           (clk),
        .resetn        (resetn),
        .f_stall       (f_stall),
        .imem_busy     (imem_busy),
        .f_instr_valid (f_instr_valid),
        .pc            (f_pc)
    );

    mmu immu (
        .vaddr  (f_pc),
        .paddr  (inst_addr),
        .cached (icached)
    );

    // the pc itself tells one fetch from the next
    sram_like_handshake imem_handshake (
        .clk       (clk),
        .resetn    (resetn),
        .unique_id (f_pc),
        .need_req  (1'b1),
        .addr_ok   (inst_addr_ok),
        .data_ok   (inst_data_ok),
        .req       (inst_req),
        .busy      (imem_busy),
        .state     (imem_state)
    );

    rdata_latch f_rdata_latch (
        .clk     (clk),
        .resetn  (resetn),
        .stall   (f_stall),
        .flush   (1'b0),
        .data_ok (inst_data_ok),
        .rdata   (inst_rdata),
        .out     (f_instr),
        .valid   (f_instr_valid)
    );

    assign inst_wr    = 1'b0;
    assign inst_size  = size_word;
    assign inst_wdata = '0;

    // ----------------------------------------
    // data path
    // ----------------------------------------

    // one count per finished access, keeps repeated addresses apart
    always_ff @(posedge clk) begin
        if (!resetn) begin
            data_count <= 32'd0;
        end else if (m_req && data_data_ok) begin
            data_count <= data_count + 32'd1;
        end
    end

    mmu dmmu (
        .vaddr  (m_vaddr),
        .paddr  (data_addr),
        .cached (dcached)
    );

    sram_like_handshake dmem_handshake (
        .clk       (clk),
        .resetn    (resetn),
        .unique_id (data_count),
        .need_req  (m_req),
        .addr_ok   (data_addr_ok),
        .data_ok   (data_data_ok),
        .req       (data_req),
        .busy      (dmem_busy),
        .state     ()
    );

    // store acks carry no read data
    assign load_ok = data_data_ok && !m_wr;

    rdata_latch m_rdata_latch (
        .clk     (clk),
        .resetn  (resetn),
        .stall   (m_stall),
        .flush   (m_flush),
        .data_ok (load_ok),
        .rdata   (data_rdata),
        .out     (m_rdata),
        .valid   (m_rdata_valid)
    );

    assign data_wr    = m_wr;
    assign data_size  = m_size;
    assign data_wdata = m_wdata;
    assign m_busy     = dmem_busy;
    assign m_done     = data_data_ok;

    // ----------------------------------------
    // checks across fetch and handshake
    // ----------------------------------------
    a_pc_stable_in_fetch: assert property (@(posedge clk) disable iff (!resetn)
        (imem_state != hs_idle && !inst_data_ok) |=> $stable(f_pc))
        else $error("pc moved during an open fetch");

endmodule

`default_nettype wire

// ==== verification/mem_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_checker (
    input  logic               clk,
    input  logic               resetn,
    input  logic               f_stall,
    input  logic               m_stall,
    input  logic               m_flush,
    input  logic               m_req,
    input  logic               m_wr,
    input  cpu_pkg::mem_size_t m_size,
    input  logic [31:0]        m_vaddr,
    input  logic [31:0]        m_wdata,
    input  logic               inst_req,
    input  logic               inst_wr,
    input  cpu_pkg::mem_size_t inst_size,
    input  logic [31:0]        inst_wdata,
    input  logic               inst_addr_ok,
    input  logic               inst_data_ok,
    input  logic [31:0]        inst_addr,
    input  logic               icached,
    input  logic               data_req,
    input  logic               data_wr,
    input  cpu_pkg::mem_size_t data_size,
    input  logic [31:0]        data_wdata,
    input  logic               data_addr_ok,
    input  logic               data_data_ok,
    input  logic [31:0]        data_addr,
    input  logic               dcached,
    input  logic [31:0]        f_pc,
    input  logic [31:0]        f_instr,
    input  logic               f_instr_valid,
    input  logic [31:0]        m_rdata,
    input  logic               m_rdata_valid,
    input  logic               m_busy,
    input  logic               m_done,
    input  logic [31:0]        test_id,
    input  logic [31:0]        exp_rdata,
    input  logic               test_end,
    output int                 error_count,
    output int                 pass_count,
    output int                 fail_count
);
    import cpu_pkg::*;

    int          errs = 0;
    int          passed = 0;
    int          failed = 0;
    int          test_errors = 0;
    int          req_count = 0;
    int          stuck_cycles = 0;
    logic        after_reset = 1'b0;
    logic        held_exp = 1'b0;
    logic        inst_held_exp = 1'b0;
    logic        inst_valid_exp;
    logic        load_done;
    logic        m_valid_exp;
    logic        inst_req_q = 1'b0;
    logic        inst_ack_q = 1'b0;
    logic        data_req_q = 1'b0;
    logic        data_ack_q = 1'b0;
    logic [31:0] pc_exp = 32'h0;

    assign error_count = errs;
    assign pass_count  = passed;
    assign fail_count  = failed;

    // kseg0 and kseg1 both start with 2'b10
    function automatic logic [31:0] to_physical(input logic [31:0] vaddr);
        if (vaddr[31:30] == 2'b10) begin
            return {3'b000, vaddr[28:0]};
        end
        return vaddr;
    endfunction

    function automatic logic in_kseg0(input logic [31:0] vaddr);
        return vaddr[31:29] == 3'b100;
    endfunction

    task automatic report_error(input string msg);
        $display("error %0t ns: %s", $time, msg);
        errs = errs + 1;
        test_errors = test_errors + 1;
    endtask

    always @(posedge clk) begin
        if (!resetn) begin
            after_reset   = 1'b1;
            held_exp      = 1'b0;
            inst_held_exp = 1'b0;
            stuck_cycles  = 0;
            pc_exp        = reset_pc;
            inst_req_q    = 1'b0;
            data_req_q    = 1'b0;
        end else begin
            if (after_reset) begin
                if (inst_req || data_req || f_instr_valid || m_rdata_valid) begin
                    report_error("bus request or valid output high right after reset");
                end
                if (inst_addr != 32'h1fc0_0000 || icached) begin
                    report_error($sformatf("first inst_addr %h icached %b", inst_addr, icached));
                end
                $display("reset check: %s", test_errors == 0 ? "pass" : "fail");
                test_errors = 0;
                after_reset = 1'b0;
            end

            // ----------------------------------------
            // sram-like bus rules
            // ----------------------------------------
            if (inst_req_q && !inst_ack_q && !inst_req) begin
                report_error("inst_req dropped before inst_addr_ok");
            end
            if (data_req_q && !data_ack_q && !data_req) begin
                report_error("data_req dropped before data_addr_ok");
            end
            if (inst_req && (inst_addr != to_physical(f_pc) || icached != in_kseg0(f_pc))) begin
                report_error($sformatf("inst_addr %h icached %b for pc %h",
                    inst_addr, icached, f_pc));
            end
            if (inst_req && (inst_wr || inst_size != size_word || inst_wdata != 32'h0)) begin
                report_error($sformatf("fetch with inst_wr %b inst_size %0d inst_wdata %h",
                    inst_wr, inst_size, inst_wdata));
            end
            if (data_req && (data_addr != to_physical(m_vaddr) || dcached != in_kseg0(m_vaddr)))
            begin
                report_error($sformatf("data_addr %h dcached %b for vaddr %h",
                    data_addr, dcached, m_vaddr));
            end
            if (data_req && (data_wr != m_wr || data_size != m_size ||
                data_wdata != m_wdata)) begin
                report_error($sformatf("data_wr %b size %0d wdata %h for wr %b size %0d wdata %h",
                    data_wr, data_size, data_wdata, m_wr, m_size, m_wdata));
            end
            if (data_req && data_addr_ok) begin
                req_count = req_count + 1;
            end

            // ----------------------------------------
            // fetch stream
            // ----------------------------------------
            inst_valid_exp = inst_data_ok || inst_held_exp;
            if (f_instr_valid != inst_valid_exp) begin
                report_error($sformatf("f_instr_valid %b, expected %b",
                    f_instr_valid, inst_valid_exp));
            end
            if (f_pc != pc_exp) begin
                report_error($sformatf("f_pc %h, expected %h", f_pc, pc_exp));
            end
            if (inst_valid_exp && f_instr != (to_physical(pc_exp) ^ 32'h5a5a_0000)) begin
                report_error($sformatf("f_instr %h at pc %h", f_instr, pc_exp));
            end
            if (inst_valid_exp && !f_stall) begin
                pc_exp       = pc_exp + 32'd4;
                stuck_cycles = 0;
            end else if (!f_stall) begin
                stuck_cycles = stuck_cycles + 1;
                if (stuck_cycles > 12) begin
                    report_error("fetch made no progress for 12 unstalled cycles");
                    stuck_cycles = 0;
                end
            end
            if (inst_data_ok) begin
                inst_held_exp = f_stall;
            end else if (!f_stall) begin
                inst_held_exp = 1'b0;
            end

            // ----------------------------------------
            // load results
            // ----------------------------------------
            if (m_done != data_data_ok) begin
                report_error($sformatf("m_done %b, expected %b", m_done, data_data_ok));
            end
            if (m_busy != (m_req && !data_data_ok)) begin
                report_error($sformatf("m_busy %b, expected %b",
                    m_busy, m_req && !data_data_ok));
            end
            load_done   = data_data_ok && !m_wr;
            m_valid_exp = load_done || held_exp;
            if (m_rdata_valid != m_valid_exp) begin
                report_error($sformatf("m_rdata_valid %b, expected %b",
                    m_rdata_valid, m_valid_exp));
            end
            if (m_valid_exp && m_rdata != exp_rdata) begin
                report_error($sformatf("m_rdata %h, expected %h", m_rdata, exp_rdata));
            end
            if (m_flush) begin
                held_exp = 1'b0;
            end else if (load_done) begin
                held_exp = m_stall;
            end else if (!m_stall) begin
                held_exp = 1'b0;
            end

            inst_req_q = inst_req;
            inst_ack_q = inst_addr_ok;
            data_req_q = data_req;
            data_ack_q = data_addr_ok;

            if (test_end) begin
                if (req_count != 1) begin
                    report_error($sformatf("%0d data requests accepted, expected 1", req_count));
                end
                if (test_errors == 0) begin
                    passed = passed + 1;
                end else begin
                    failed = failed + 1;
                end
                $display("test %0d: %s, %0d errors", test_id,
                    test_errors == 0 ? "pass" : "fail", test_errors);
                test_errors = 0;
                req_count   = 0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== verification/tb_mem_frontend.sv ====
`timescale 1ns/1ps
`default_nettype none

// one sram-like slave with random addr_ok and data_ok delays
module sram_bus_model (
    input  logic        clk,
    input  logic        resetn,
    input  logic        inst_rule,
    input  logic        req,
    input  logic        wr,
    input  logic [31:0] addr,
    input  logic [31:0] wdata,
    output logic        addr_ok,
    output logic        data_ok,
    output logic [31:0] rdata
);
    logic [31:0] mem [bit [31:0]];
    logic [31:0] addr_q;
    logic [31:0] wdata_q;
    logic        wr_q;
    int          phase;
    int          cnt;

    initial begin
        addr_ok = 1'b0;
        data_ok = 1'b0;
        rdata   = 32'h0;
        phase   = 0;
        cnt     = 0;
    end

    always @(negedge clk) begin
        addr_ok = 1'b0;
        data_ok = 1'b0;
        if (!resetn) begin
            phase = 0;
        end else begin
            if (phase == 0 && req) begin
                cnt   = $urandom % 4;
                phase = 1;
            end
            if (phase == 1) begin
                if (cnt == 0) begin
                    addr_ok = 1'b1;
                    addr_q  = addr;
                    wr_q    = wr;
                    wdata_q = wdata;
                    cnt     = $urandom % 4;
                    phase   = 2;
                end else begin
                    cnt = cnt - 1;
                end
            end else if (phase == 2) begin
                if (cnt == 0) begin
                    data_ok = 1'b1;
                    if (inst_rule) begin
                        rdata = addr_q ^ 32'h5a5a_0000;
                    end else if (wr_q) begin
                        mem[addr_q] = wdata_q;
                    end else if (mem.exists(addr_q)) begin
                        rdata = mem[addr_q];
                    end else begin
                        rdata = addr_q;
                    end
                    phase = 0;
                end else begin
                    cnt = cnt - 1;
                end
            end
        end
    end

endmodule

module tb_mem_frontend;
    import cpu_pkg::*;

    logic        clk;
    logic        resetn;
    logic        f_stall;
    logic        m_stall;
    logic        m_flush;
    logic        m_req;
    logic        m_wr;
    mem_size_t   m_size;
    logic [31:0] m_vaddr;
    logic [31:0] m_wdata;

    logic        inst_req, inst_wr, inst_addr_ok, inst_data_ok, icached;
    mem_size_t   inst_size;
    logic [31:0] inst_addr, inst_wdata, inst_rdata;
    logic        data_req, data_wr, data_addr_ok, data_data_ok, dcached;
    mem_size_t   data_size;
    logic [31:0] data_addr, data_wdata, data_rdata;
    logic [31:0] f_pc, f_instr, m_rdata;
    logic        f_instr_valid, m_rdata_valid, m_busy, m_done;

    logic [31:0] stim [0:255];
    logic [31:0] test_id;
    logic [31:0] exp_rdata;
    logic [31:0] stall_pat;
    logic [4:0]  pat_idx;
    logic        test_end;
    int          num_tests = 0;
    int          error_count, pass_count, fail_count;

    mem_frontend u_mem_frontend (.*);

    sram_bus_model imem_model (
        .clk(clk), .resetn(resetn), .inst_rule(1'b1), .req(inst_req), .wr(inst_wr),
        .addr(inst_addr), .wdata(inst_wdata), .addr_ok(inst_addr_ok),
        .data_ok(inst_data_ok), .rdata(inst_rdata)
    );

    sram_bus_model dmem_model (
        .clk(clk), .resetn(resetn), .inst_rule(1'b0), .req(data_req), .wr(data_wr),
        .addr(data_addr), .wdata(data_wdata), .addr_ok(data_addr_ok),
        .data_ok(data_data_ok), .rdata(data_rdata)
    );

    mem_checker u_mem_checker (.*);

    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    // ----------------------------------------
    // stimulus
    // ----------------------------------------

    // one falling edge, f_stall follows the test's pattern
    task automatic next_cycle();
        @(negedge clk);
        f_stall = stall_pat[pat_idx];
        pat_idx = pat_idx + 5'd1;
    endtask

    task automatic run_test(input int base);
        logic done;
        test_id   = stim[base];
        stall_pat = stim[base + 1];
        m_stall   = stim[base + 2][0];
        m_wr      = stim[base + 3][0];
        m_vaddr   = stim[base + 4];
        m_wdata   = stim[base + 5];
        exp_rdata = stim[base + 6];
        m_req     = 1'b1;
        done      = 1'b0;
        while (!done) begin
            @(posedge clk);
            done = m_done;
            next_cycle();
        end
        m_req = 1'b0;
        if (m_stall) begin
            next_cycle();
            next_cycle();
            m_flush = 1'b1;
            next_cycle();
            m_flush = 1'b0;
            next_cycle();
            m_stall = 1'b0;
        end
        // let the fetch stream run on
        repeat (6) next_cycle();
        test_end = 1'b1;
        next_cycle();
        test_end = 1'b0;
    endtask

    initial begin
        void'($urandom(66));
        resetn    = 1'b0;
        f_stall   = 1'b0;
        m_stall   = 1'b0;
        m_flush   = 1'b0;
        m_req     = 1'b0;
        m_wr      = 1'b0;
        m_size    = size_word;
        m_vaddr   = 32'h0;
        m_wdata   = 32'h0;
        test_id   = 32'h0;
        exp_rdata = 32'h0;
        stall_pat = 32'h0;
        pat_idx   = 5'd0;
        test_end  = 1'b0;
        for (int i = 0; i < 256; i++) begin
            stim[i] = 32'hffff_ffff;
        end
        $readmemh("verification/mem_stimulus.txt", stim);
        while (num_tests < 36 && stim[num_tests * 7] != 32'hffff_ffff) begin
            num_tests = num_tests + 1;
        end

        repeat (2) @(posedge clk);
        @(negedge clk);
        resetn = 1'b1;
        for (int t = 0; t < num_tests; t++) begin
            run_test(t * 7);
        end
        repeat (2) @(posedge clk);

        $display("tests %0d, passed %0d, failed %0d, errors %0d",
            num_tests, pass_count, fail_count, error_count);
        if (error_count == 0 && num_tests > 0 && pass_count == num_tests) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    // watchdog, 40 cycles per test line
    initial begin
        wait (num_tests > 0);
        repeat (num_tests * 40 + 4) @(posedge clk);
        $display("timeout: tests did not finish within %0d cycles", num_tests * 40 + 4);
        $display("Verification failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== mem_frontend.f ====
rtl/cpu_pkg.sv
rtl/mmu.sv
rtl/sram_like_handshake.sv
rtl/rdata_latch.sv
rtl/fetch_unit.sv
rtl/mem_frontend.sv
verification/mem_checker.sv
verification/tb_mem_frontend.sv

// ==== run.sh ====
#!/bin/sh
# builds the memory front end testbench with verilator and runs it
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
    --top-module tb_mem_frontend \
    -f mem_frontend.f \
    -o sim_mem_frontend

./obj_dir/sim_mem_frontend | tee sim.log

if grep -qx "Verification passed" sim.log; then
    echo "simulation run ok"
else
    echo "simulation run not ok, see sim.log"
    exit 1
fi

// ==== verification/mem_stimulus.txt ====
// id  f_stall_pattern  hold_flush  m_wr  m_vaddr   m_wdata   expected_m_rdata
// hold_flush 1: m_stall over the load, m_flush while the word is held
01 00000000 0 1 80001000 11223344 00000000
02 ffff0000 0 0 80001000 00000000 11223344
03 00000000 0 0 80001000 00000000 11223344
04 f0f0f0f0 0 0 a0001000 00000000 11223344
05 cccccccc 0 0 a0002000 00000000 00002000
06 aaaaaaaa 0 0 00003000 00000000 00003000
07 0ff00ff0 0 1 00003000 deadbeef 00000000
08 33333333 1 0 00003000 00000000 deadbeef
09 ff00ff00 1 0 80001000 00000000 11223344
0a 0000ffff 0 1 a0004000 cafef00d 00000000
0b 5a5a5a5a 0 0 80004000 00000000 cafef00d
0c e0e0e0e0 0 0 c0005000 00000000 c0005000
0d 00000000 0 1 80001000 55aa55aa 00000000
0e 7777eeee 1 0 a0001000 00000000 55aa55aa
0f 0f0f0f0f 0 0 a0001000 00000000 55aa55aa
